//--- common/dec_ctrl_if.sv
// control bundle from the instruction decoder to the handoff register
// decoder drives every field, handoff only samples them on capture
`timescale 1ns/1ps

interface dec_ctrl_if import decode_pkg::*; ();

	// execute controls
	alu_src_t    alu_src;
	opcode_t     alu_op;
	logic        branch;
	logic        jump;
	// memory controls
	logic        mem_en;
	logic        mem_wrt;
	// writeback controls
	result_sel_t result_sel;
	logic        wb_en;
	reg_sel_t    wb_sel;
	// extended immediate, bad opcode flag
	word_t       imm;
	logic        illegal;

	modport decoder (
		output alu_src, alu_op, branch, jump,
		output mem_en, mem_wrt,
		output result_sel, wb_en, wb_sel,
		output imm, illegal
	);

	modport handoff (
		input alu_src, alu_op, branch, jump,
		input mem_en, mem_wrt,
		input result_sel, wb_en, wb_sel,
		input imm, illegal
	);

endinterface

//--- common/decode_cfg.svh
// sizes and instruction field positions for the decode stage
// included by the package and by any module that slices instruction fields
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath width
`define DEC_XLEN 32

// register file depth
`define DEC_NREGS 32

// opcode lives in the top five bits
`define DEC_OP_HI 31
`define DEC_OP_LO 27

// destination and source register fields
`define DEC_RD_HI 26
`define DEC_RD_LO 22
`define DEC_RS1_HI 21
`define DEC_RS1_LO 17
`define DEC_RS2_HI 16
`define DEC_RS2_LO 12

// JAL drops the return address here
`define DEC_LINK_REG 31

`endif

//--- common/decode_pkg.sv
// shared types and encodings for the decode stage
// modules pull these in with a wildcard import in their header
`include "decode_cfg.svh"

package decode_pkg;

	// data and instruction words
	typedef logic [`DEC_XLEN-1:0] word_t;
	typedef logic [`DEC_XLEN-1:0] instr_t;

	// register number and opcode field
	typedef logic [$clog2(`DEC_NREGS)-1:0] reg_sel_t;
	typedef logic [`DEC_OP_HI-`DEC_OP_LO:0] opcode_t;

	// alu ops
	localparam opcode_t OP_ADD  = 5'd0;
	localparam opcode_t OP_ADDI = 5'd1;
	localparam opcode_t OP_SUB  = 5'd2;
	localparam opcode_t OP_SUBI = 5'd3;
	localparam opcode_t OP_AND  = 5'd4;
	localparam opcode_t OP_OR   = 5'd5;
	localparam opcode_t OP_XOR  = 5'd6;
	localparam opcode_t OP_NEG  = 5'd7;
	localparam opcode_t OP_SLL  = 5'd8;
	localparam opcode_t OP_SLR  = 5'd9;
	localparam opcode_t OP_SAR  = 5'd10;
	// memory ops
	localparam opcode_t OP_LD   = 5'd11;
	localparam opcode_t OP_LDI  = 5'd12;
	localparam opcode_t OP_ST   = 5'd13;
	localparam opcode_t OP_STI  = 5'd14;
	localparam opcode_t OP_NOP  = 5'd15;
	// branches and jumps
	localparam opcode_t OP_BEQ  = 5'd16;
	localparam opcode_t OP_BNE  = 5'd17;
	localparam opcode_t OP_BON  = 5'd18;
	localparam opcode_t OP_BNN  = 5'd19;
	localparam opcode_t OP_J    = 5'd20;
	localparam opcode_t OP_JR   = 5'd21;
	localparam opcode_t OP_JAL  = 5'd22;
	// gap 23..30 unused, RIN sits at the very top
	localparam opcode_t OP_RIN  = 5'd31;

	// second alu operand
	typedef logic [1:0] alu_src_t;
	localparam alu_src_t SRC_REG = 2'd0;
	localparam alu_src_t SRC_IMM = 2'd1;

	// writeback source
	typedef logic [1:0] result_sel_t;
	localparam result_sel_t RES_ALU = 2'd0;
	localparam result_sel_t RES_MEM = 2'd1;
	localparam result_sel_t RES_PC  = 2'd2;

	// output slot FSM
	typedef enum logic [1:0] {
		IDLE,
		HOLD,
		WAIT_DROP
	} handoff_state_t;

endpackage

//--- flist.f
+incdir+common
common/decode_pkg.sv
common/dec_ctrl_if.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/decode_handoff.sv
hdl/decode_stage.sv
verification/decode_stage_assert.sv
verification/tb_decode_stage.sv

//--- hdl/decode_handoff.sv
// one-slot output register between decode and execute
// runs the fetch-side and execute-side four-phase handshakes
// flush turns the held item into a bubble but its handshake still completes
`timescale 1ns/1ps

module decode_handoff
	import decode_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	// fetch side
	input  logic        in_req,
	output logic        in_ack,
	input  word_t       pc_next,
	// operands and decoded control
	input  word_t       opnd_1,
	input  word_t       opnd_2,
	dec_ctrl_if.handoff ctrl,
	input  logic        flush,
	// execute side
	output logic        out_req,
	input  logic        out_ack,
	output word_t       out_pc_next,
	output word_t       reg_1_data,
	output word_t       reg_2_data,
	output word_t       imm,
	output alu_src_t    alu_src,
	output opcode_t     alu_op,
	output logic        branch,
	output logic        jump,
	output logic        mem_en,
	output logic        mem_wrt,
	output result_sel_t result_sel,
	output logic        wb_en,
	output reg_sel_t    wb_sel,
	output logic        illegal
);

	handoff_state_t state;
	logic           capture;

	// new item only when the slot is empty and fetch has a fresh request
	assign capture = in_req && !in_ack && (state == IDLE);

	// handshake control
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			in_ack  <= 1'b0;
			out_req <= 1'b0;
		end else begin
			// in_ack drops once fetch has released req
			if (capture) begin
				in_ack <= 1'b1;
			end else if (!in_req) begin
				in_ack <= 1'b0;
			end
			case (state)
				IDLE: begin
					if (capture) begin
						state   <= HOLD;
						out_req <= 1'b1;
					end
				end
				// waiting for execute to take it
				HOLD: begin
					if (out_ack) begin
						state   <= WAIT_DROP;
						out_req <= 1'b0;
					end
				end
				// slot frees after ack goes back low
				WAIT_DROP: begin
					if (!out_ack) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// enables and illegal flag of the held item
	// flush clears only the enables while an item sits here
	always_ff @(posedge clk) begin
		if (rst) begin
			branch  <= 1'b0;
			jump    <= 1'b0;
			mem_en  <= 1'b0;
			mem_wrt <= 1'b0;
			wb_en   <= 1'b0;
			illegal <= 1'b0;
		end else if (capture) begin
			branch  <= ctrl.branch;
			jump    <= ctrl.jump;
			mem_en  <= ctrl.mem_en;
			mem_wrt <= ctrl.mem_wrt;
			wb_en   <= ctrl.wb_en;
			illegal <= ctrl.illegal;
		end else if (flush && (state != IDLE)) begin
			branch  <= 1'b0;
			jump    <= 1'b0;
			mem_en  <= 1'b0;
			mem_wrt <= 1'b0;
			wb_en   <= 1'b0;
		end
	end

	// data half of the payload stays put under flush
	always_ff @(posedge clk) begin
		if (capture) begin
			out_pc_next <= pc_next;
			reg_1_data  <= opnd_1;
			reg_2_data  <= opnd_2;
			imm         <= ctrl.imm;
			alu_src     <= ctrl.alu_src;
			alu_op      <= ctrl.alu_op;
			result_sel  <= ctrl.result_sel;
			wb_sel      <= ctrl.wb_sel;
		end
	end

endmodule

//--- hdl/decode_stage.sv
// decode stage top level
// register read and opcode decode run in parallel, the handoff slot registers
// both and talks four-phase req/ack to fetch and to execute
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage
	import decode_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	// from fetch
	input  logic        in_req,
	output logic        in_ack,
	input  instr_t      instr,
	input  word_t       pc_next,
	// writeback port
	input  logic        reg_wrt_en,
	input  reg_sel_t    reg_wrt_sel,
	input  word_t       reg_wrt_data,
	// kill the held item
	input  logic        flush,
	// to execute
	output logic        out_req,
	input  logic        out_ack,
	output word_t       out_pc_next,
	output word_t       reg_1_data,
	output word_t       reg_2_data,
	output word_t       imm,
	output alu_src_t    alu_src,
	output opcode_t     alu_op,
	output logic        branch,
	output logic        jump,
	output logic        mem_en,
	output logic        mem_wrt,
	output result_sel_t result_sel,
	output logic        wb_en,
	output reg_sel_t    wb_sel,
	output logic        illegal
);

	// source register numbers straight from the instruction
	reg_sel_t rs1;
	reg_sel_t rs2;
	// operands after bypass
	word_t    opnd_1;
	word_t    opnd_2;

	dec_ctrl_if dec_ctrl ();

	assign rs1 = instr[`DEC_RS1_HI:`DEC_RS1_LO];
	assign rs2 = instr[`DEC_RS2_HI:`DEC_RS2_LO];

	reg_file u_reg_file (
		.clk       (clk),
		.rst       (rst),
		.rd_sel_1  (rs1),
		.rd_sel_2  (rs2),
		.rd_data_1 (opnd_1),
		.rd_data_2 (opnd_2),
		.wrt_en    (reg_wrt_en),
		.wrt_sel   (reg_wrt_sel),
		.wrt_data  (reg_wrt_data)
	);

	instr_decoder u_instr_decoder (
		.instr (instr),
		.ctrl  (dec_ctrl.decoder)
	);

	decode_handoff u_decode_handoff (
		.clk         (clk),
		.rst         (rst),
		.in_req      (in_req),
		.in_ack      (in_ack),
		.pc_next     (pc_next),
		.opnd_1      (opnd_1),
		.opnd_2      (opnd_2),
		.ctrl        (dec_ctrl.handoff),
		.flush       (flush),
		.out_req     (out_req),
		.out_ack     (out_ack),
		.out_pc_next (out_pc_next),
		.reg_1_data  (reg_1_data),
		.reg_2_data  (reg_2_data),
		.imm         (imm),
		.alu_src     (alu_src),
		.alu_op      (alu_op),
		.branch      (branch),
		.jump        (jump),
		.mem_en      (mem_en),
		.mem_wrt     (mem_wrt),
		.result_sel  (result_sel),
		.wb_en       (wb_en),
		.wb_sel      (wb_sel),
		.illegal     (illegal)
	);

endmodule

//--- hdl/instr_decoder.sv
// opcode decode for the decode stage, purely combinational
// turns one instruction into execute/memory/writeback control and an immediate
// unknown opcodes come out as illegal with every enable low
`timescale 1ns/1ps
`include "decode_cfg.svh"

module instr_decoder
	import decode_pkg::*;
(
	input  instr_t            instr,
	dec_ctrl_if.decoder       ctrl
);

	// top bits of the two immediate fields
	localparam int IMM_S_HI = 10;
	localparam int IMM_L_HI = 21;

	opcode_t  opcode;
	reg_sel_t rd;
	word_t    imm_s;
	word_t    imm_l;

	assign opcode = instr[`DEC_OP_HI:`DEC_OP_LO];
	assign rd     = instr[`DEC_RD_HI:`DEC_RD_LO];

	// short field for alu-imm, mem-imm and branch offsets
	assign imm_s = {{(`DEC_XLEN-IMM_S_HI-1){instr[IMM_S_HI]}}, instr[IMM_S_HI:0]};
	// long field for J / JAL targets
	assign imm_l = {{(`DEC_XLEN-IMM_L_HI-1){instr[IMM_L_HI]}}, instr[IMM_L_HI:0]};

	always_comb begin
		// everything off unless the opcode asks for it
		ctrl.alu_src    = SRC_REG;
		ctrl.alu_op     = OP_ADD;
		ctrl.branch     = 1'b0;
		ctrl.jump       = 1'b0;
		ctrl.mem_en     = 1'b0;
		ctrl.mem_wrt    = 1'b0;
		ctrl.result_sel = RES_ALU;
		ctrl.wb_en      = 1'b0;
		ctrl.wb_sel     = '0;
		ctrl.imm        = '0;
		ctrl.illegal    = 1'b0;

		case (opcode)
			// register-register alu, op passes straight through
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_NEG, OP_SLL, OP_SLR, OP_SAR: begin
				ctrl.alu_op = opcode;
				ctrl.wb_en  = 1'b1;
				ctrl.wb_sel = rd;
			end
			// alu with immediate operand
			OP_ADDI, OP_SUBI: begin
				ctrl.alu_op  = opcode;
				ctrl.alu_src = SRC_IMM;
				ctrl.wb_en   = 1'b1;
				ctrl.wb_sel  = rd;
				ctrl.imm     = imm_s;
			end
			// loads, address formed by an add
			OP_LD, OP_LDI: begin
				ctrl.mem_en     = 1'b1;
				ctrl.result_sel = RES_MEM;
				ctrl.wb_en      = 1'b1;
				ctrl.wb_sel     = rd;
				if (opcode == OP_LDI) begin
					ctrl.alu_src = SRC_IMM;
					ctrl.imm     = imm_s;
				end
			end
			// stores, no writeback
			OP_ST, OP_STI: begin
				ctrl.mem_en  = 1'b1;
				ctrl.mem_wrt = 1'b1;
				if (opcode == OP_STI) begin
					ctrl.alu_src = SRC_IMM;
					ctrl.imm     = imm_s;
				end
			end
			OP_NOP: begin
				// defaults already describe a nop
			end
			// compare via subtract
			OP_BEQ, OP_BNE, OP_BON, OP_BNN: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = OP_SUB;
				ctrl.imm    = imm_s;
			end
			OP_J: begin
				ctrl.jump = 1'b1;
				ctrl.imm  = imm_l;
			end
			// target comes from rs1
			OP_JR: begin
				ctrl.jump = 1'b1;
			end
			// return address into the link register
			OP_JAL: begin
				ctrl.jump       = 1'b1;
				ctrl.wb_en      = 1'b1;
				ctrl.wb_sel     = reg_sel_t'(`DEC_LINK_REG);
				ctrl.result_sel = RES_PC;
				ctrl.imm        = imm_l;
			end
			// RIN plus the unused gap
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

//--- hdl/reg_file.sv
// general purpose register file for decode
// two async reads, one clocked write, same-cycle write forwarded to reads
`timescale 1ns/1ps
`include "decode_cfg.svh"

module reg_file
	import decode_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	// read ports
	input  reg_sel_t rd_sel_1,
	input  reg_sel_t rd_sel_2,
	output word_t    rd_data_1,
	output word_t    rd_data_2,
	// write port from writeback
	input  logic     wrt_en,
	input  reg_sel_t wrt_sel,
	input  word_t    wrt_data
);

	// storage
	word_t regs [`DEC_NREGS];

	// hit flags for the bypass
	logic hit_1;
	logic hit_2;

	// whole array goes to zero on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DEC_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrt_en) begin
			regs[wrt_sel] <= wrt_data;
		end
	end

	// writer targets a register being read this cycle
	assign hit_1 = wrt_en && (wrt_sel == rd_sel_1);
	assign hit_2 = wrt_en && (wrt_sel == rd_sel_2);

	// new value wins over the stored one
	always_comb begin
		if (hit_1) begin
			rd_data_1 = wrt_data;
		end else begin
			rd_data_1 = regs[rd_sel_1];
		end
	end

	always_comb begin
		if (hit_2) begin
			rd_data_2 = wrt_data;
		end else begin
			rd_data_2 = regs[rd_sel_2];
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f flist.f \
	--top-module tb_decode_stage -o tb_decode_stage > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_decode_stage +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

//--- verification/decode_stage_assert.sv
// protocol checks on the decode stage top level
// attached to every decode_stage instance with the bind at the bottom
`timescale 1ns/1ps

module decode_stage_assert
	import decode_pkg::*;
(
	input logic        clk,
	input logic        rst,
	input logic        in_req,
	input logic        in_ack,
	input logic        out_req,
	input logic        out_ack,
	input word_t       out_pc_next,
	input word_t       reg_1_data,
	input word_t       reg_2_data,
	input word_t       imm,
	input alu_src_t    alu_src,
	input opcode_t     alu_op,
	input logic        branch,
	input logic        jump,
	input logic        mem_en,
	input logic        mem_wrt,
	input result_sel_t result_sel,
	input logic        wb_en,
	input reg_sel_t    wb_sel,
	input logic        illegal
);

	// running count of failed checks
	int fail_count = 0;

	// handshake outputs come out of reset low
	a_reset_low: assert property (@(posedge clk) rst |=> (!in_ack && !out_req))
		else begin
			fail_count++;
			$error("in_ack or out_req high after reset");
		end

	// no early withdrawal of the offer
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		(out_req && !out_ack) |=> out_req)
		else begin
			fail_count++;
			$error("out_req dropped before out_ack");
		end

	// data half of the payload frozen while offered
	a_payload_stable: assert property (@(posedge clk) disable iff (rst)
		(out_req && !out_ack) |=> $stable({out_pc_next, reg_1_data, reg_2_data, imm,
			alu_src, alu_op, result_sel, wb_sel, illegal}))
		else begin
			fail_count++;
			$error("payload changed while out_req was high");
		end

	// flush may only clear enables, never set one
	a_enables_fall_only: assert property (@(posedge clk) disable iff (rst)
		(out_req && !out_ack) |=>
		(({wb_en, mem_en, mem_wrt, branch, jump} & ~$past({wb_en, mem_en, mem_wrt,
			branch, jump})) == 5'd0))
		else begin
			fail_count++;
			$error("an enable rose while the item was held");
		end

	// ack only answers a request
	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(in_ack) |-> $past(in_req))
		else begin
			fail_count++;
			$error("in_ack rose without in_req");
		end

	// bad opcode means a dead item
	a_illegal_quiet: assert property (@(posedge clk) disable iff (rst)
		illegal |-> !(wb_en || mem_en || mem_wrt || branch || jump))
		else begin
			fail_count++;
			$error("illegal item carries an enable");
		end

endmodule

bind decode_stage decode_stage_assert u_decode_stage_assert (
	.clk         (clk),
	.rst         (rst),
	.in_req      (in_req),
	.in_ack      (in_ack),
	.out_req     (out_req),
	.out_ack     (out_ack),
	.out_pc_next (out_pc_next),
	.reg_1_data  (reg_1_data),
	.reg_2_data  (reg_2_data),
	.imm         (imm),
	.alu_src     (alu_src),
	.alu_op      (alu_op),
	.branch      (branch),
	.jump        (jump),
	.mem_en      (mem_en),
	.mem_wrt     (mem_wrt),
	.result_sel  (result_sel),
	.wb_en       (wb_en),
	.wb_sel      (wb_sel),
	.illegal     (illegal)
);

//--- verification/tb_decode_stage.sv
// testbench for the decode stage
// plays fetch, writeback and execute, checks each payload against a reference model
`timescale 1ns/1ps

module tb_decode_stage
	import decode_pkg::*;
();

	localparam int TMO = 200;

	logic        clk;
	logic        rst;
	logic        in_req;
	logic        in_ack;
	instr_t      instr;
	word_t       pc_next;
	logic        reg_wrt_en;
	reg_sel_t    reg_wrt_sel;
	word_t       reg_wrt_data;
	logic        flush;
	logic        out_req;
	logic        out_ack;
	word_t       out_pc_next;
	word_t       reg_1_data;
	word_t       reg_2_data;
	word_t       imm;
	alu_src_t    alu_src;
	opcode_t     alu_op;
	logic        branch;
	logic        jump;
	logic        mem_en;
	logic        mem_wrt;
	result_sel_t result_sel;
	logic        wb_en;
	reg_sel_t    wb_sel;
	logic        illegal;

	// reference state
	word_t       shadow [32];
	word_t       exp_pc;
	word_t       exp_r1;
	word_t       exp_r2;
	word_t       exp_imm;
	alu_src_t    exp_alu_src;
	opcode_t     exp_alu_op;
	logic        exp_branch;
	logic        exp_jump;
	logic        exp_mem_en;
	logic        exp_mem_wrt;
	result_sel_t exp_result_sel;
	logic        exp_wb_en;
	reg_sel_t    exp_wb_sel;
	logic        exp_illegal;

	logic [31:0] rng_state = 32'h81d2d0f0;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          checks_at_start;
	int          errors_at_start;
	opcode_t     flush_ops [7] = '{OP_ADD, OP_LDI, OP_STI, OP_BNE, OP_J, OP_JAL, OP_RIN};

	decode_stage u_decode_stage (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// upper bits are the better ones
	function automatic int pick(input int n);
		return int'((lcg_next() >> 16) % 32'(n));
	endfunction

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic abort_timeout(input string what);
		$display("timed out after %0d cycles waiting for %s at t=%0t", TMO, what, $time);
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic wait_in_ack(input logic level, output int n);
		n = 0;
		while (in_ack !== level && n < TMO) begin
			step_cycle();
			n++;
		end
		if (in_ack !== level) abort_timeout("in_ack");
	endtask

	task automatic wait_out_req(input logic level, output int n);
		n = 0;
		while (out_req !== level && n < TMO) begin
			step_cycle();
			n++;
		end
		if (out_req !== level) abort_timeout("out_req");
	endtask

	// decode table and immediate rule
	task automatic calc_expected(input instr_t ins);
		opcode_t op;
		word_t   imm_short;
		word_t   imm_long;
		op = ins[31:27];
		imm_short = {{21{ins[10]}}, ins[10:0]};
		imm_long = {{10{ins[21]}}, ins[21:0]};
		exp_alu_src = SRC_REG;
		exp_alu_op = 5'd0;
		exp_branch = 1'b0;
		exp_jump = 1'b0;
		exp_mem_en = 1'b0;
		exp_mem_wrt = 1'b0;
		exp_result_sel = RES_ALU;
		exp_wb_en = 1'b0;
		exp_wb_sel = 5'd0;
		exp_imm = 32'd0;
		exp_illegal = 1'b0;
		if (op <= OP_SAR) begin
			exp_alu_op = op;
			exp_wb_en = 1'b1;
			exp_wb_sel = ins[26:22];
			if (op == OP_ADDI || op == OP_SUBI) begin
				exp_alu_src = SRC_IMM;
				exp_imm = imm_short;
			end
		end else if (op == OP_LD || op == OP_LDI) begin
			exp_mem_en = 1'b1;
			exp_alu_op = OP_ADD;
			exp_result_sel = RES_MEM;
			exp_wb_en = 1'b1;
			exp_wb_sel = ins[26:22];
			if (op == OP_LDI) begin
				exp_alu_src = SRC_IMM;
				exp_imm = imm_short;
			end
		end else if (op == OP_ST || op == OP_STI) begin
			exp_mem_en = 1'b1;
			exp_mem_wrt = 1'b1;
			exp_alu_op = OP_ADD;
			if (op == OP_STI) begin
				exp_alu_src = SRC_IMM;
				exp_imm = imm_short;
			end
		end else if (op == OP_NOP) begin
			// all fields stay zero
		end else if (op >= OP_BEQ && op <= OP_BNN) begin
			exp_branch = 1'b1;
			exp_alu_op = OP_SUB;
			exp_imm = imm_short;
		end else if (op == OP_J || op == OP_JAL) begin
			exp_jump = 1'b1;
			exp_imm = imm_long;
			if (op == OP_JAL) begin
				exp_wb_en = 1'b1;
				exp_wb_sel = 5'd31;
				exp_result_sel = RES_PC;
			end
		end else if (op == OP_JR) begin
			exp_jump = 1'b1;
		end else begin
			exp_illegal = 1'b1;
		end
	endtask

	task automatic check_payload();
		check_value("out_pc_next", out_pc_next, exp_pc);
		check_value("reg_1_data", reg_1_data, exp_r1);
		check_value("reg_2_data", reg_2_data, exp_r2);
		check_value("imm", imm, exp_imm);
		check_value("alu_src", alu_src, exp_alu_src);
		check_value("alu_op", alu_op, exp_alu_op);
		check_value("branch", branch, exp_branch);
		check_value("jump", jump, exp_jump);
		check_value("mem_en", mem_en, exp_mem_en);
		check_value("mem_wrt", mem_wrt, exp_mem_wrt);
		check_value("result_sel", result_sel, exp_result_sel);
		check_value("wb_en", wb_en, exp_wb_en);
		check_value("wb_sel", wb_sel, exp_wb_sel);
		check_value("illegal", illegal, exp_illegal);
	endtask

	// byp 1 writes rs1 and byp 2 writes rs2 in the capture cycle
	task automatic start_item(input instr_t ins, input word_t pc, input int byp);
		reg_sel_t r1;
		reg_sel_t r2;
		int       n;
		r1 = ins[21:17];
		r2 = ins[16:12];
		calc_expected(ins);
		exp_pc = pc;
		exp_r1 = shadow[r1];
		exp_r2 = shadow[r2];
		check_value("out_req", out_req, 1'b0);
		instr = ins;
		pc_next = pc;
		in_req = 1'b1;
		if (byp != 0) begin
			reg_wrt_sel = (byp == 1) ? r1 : r2;
			reg_wrt_data = lcg_next();
			reg_wrt_en = 1'b1;
			if (reg_wrt_sel == r1) exp_r1 = reg_wrt_data;
			if (reg_wrt_sel == r2) exp_r2 = reg_wrt_data;
		end
		step_cycle();
		if (reg_wrt_en) shadow[reg_wrt_sel] = reg_wrt_data;
		reg_wrt_en = 1'b0;
		wait_in_ack(1'b1, n);
		// capture was on the first edge so out_req is already up
		check_value("in_ack_extra_cycles", n, 0);
		check_value("out_req", out_req, 1'b1);
		check_payload();
	endtask

	task automatic release_fetch(input logic do_flush);
		int n;
		in_req = 1'b0;
		flush = do_flush;
		step_cycle();
		flush = 1'b0;
		check_value("in_ack", in_ack, 1'b0);
		if (do_flush) begin
			exp_wb_en = 1'b0;
			exp_mem_en = 1'b0;
			exp_mem_wrt = 1'b0;
			exp_branch = 1'b0;
			exp_jump = 1'b0;
			check_payload();
		end
		wait_in_ack(1'b0, n);
	endtask

	// a probe request sits on the input while the slot is still full
	task automatic complete_exec(input int delay, input logic probe, input instr_t p_ins,
		input word_t p_pc);
		int n;
		for (int i = 0; i < delay; i++) begin
			if (probe && i == 0) begin
				instr = p_ins;
				pc_next = p_pc;
				in_req = 1'b1;
			end
			step_cycle();
			check_value("in_ack", in_ack, 1'b0);
			check_value("out_req", out_req, 1'b1);
		end
		out_ack = 1'b1;
		step_cycle();
		wait_out_req(1'b0, n);
		check_value("out_req_extra_cycles", n, 0);
		out_ack = 1'b0;
		step_cycle();
		step_cycle();
	endtask

	task automatic take_queued(input instr_t ins, input word_t pc);
		int n;
		calc_expected(ins);
		exp_pc = pc;
		exp_r1 = shadow[ins[21:17]];
		exp_r2 = shadow[ins[16:12]];
		wait_in_ack(1'b1, n);
		check_value("out_req", out_req, 1'b1);
		check_payload();
		release_fetch(1'b0);
		complete_exec(0, 1'b0, '0, '0);
	endtask

	task automatic run_item(input instr_t ins, input word_t pc, input int byp,
		input logic do_flush, input int delay);
		start_item(ins, pc, byp);
		release_fetch(do_flush);
		complete_exec(delay, 1'b0, '0, '0);
	endtask

	// even registers through rs1, odd ones through rs2
	task automatic read_all_regs();
		instr_t ins;
		for (int i = 0; i < 16; i++) begin
			ins = {OP_ADD, 5'd1, 5'(2 * i), 5'(2 * i + 1), 12'd0};
			run_item(ins, lcg_next(), 0, 1'b0, 0);
		end
	endtask

	// writeback port alone, one register per cycle, never zero
	task automatic fill_regs();
		for (int i = 0; i < 32; i++) begin
			reg_wrt_en = 1'b1;
			reg_wrt_sel = 5'(i);
			reg_wrt_data = lcg_next() | 32'd1;
			step_cycle();
			shadow[i] = reg_wrt_data;
		end
		reg_wrt_en = 1'b0;
	endtask

	task automatic test_start();
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic test_end(input string name);
		tests++;
		$display("test %-12s checks %0d errors %0d", name, checks - checks_at_start,
			errors - errors_at_start);
	endtask

	initial begin
		instr_t      ins;
		instr_t      probe;
		word_t       probe_pc;
		logic [31:0] r;
		int          total;
		rst = 1'b1;
		in_req = 1'b0;
		instr = '0;
		pc_next = '0;
		reg_wrt_en = 1'b0;
		reg_wrt_sel = '0;
		reg_wrt_data = '0;
		flush = 1'b0;
		out_ack = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// handshake idle and every register zero
		test_start();
		check_value("in_ack", in_ack, 1'b0);
		check_value("out_req", out_req, 1'b0);
		read_all_regs();
		test_end("reset");

		// each legal opcode with both immediate signs
		test_start();
		for (int i = 0; i <= 22; i++) begin
			for (int k = 0; k < 2; k++) begin
				r = lcg_next();
				ins = {5'(i), r[26:0]};
				ins[10] = (k == 0);
				ins[21] = (k == 0);
				run_item(ins, lcg_next(), 0, 1'b0, pick(3));
			end
		end
		test_end("legal_ops");

		// writebacks in the capture cycle go through the bypass
		test_start();
		for (int i = 0; i < 24; i++) begin
			r = lcg_next();
			ins = {5'(pick(23)), r[26:0]};
			run_item(ins, lcg_next(), pick(3), 1'b0, pick(4));
		end
		test_end("operands");

		// long execute stalls with a waiting fetch request
		test_start();
		for (int i = 0; i < 6; i++) begin
			r = lcg_next();
			ins = {5'(pick(23)), r[26:0]};
			r = lcg_next();
			probe = {5'(pick(23)), r[26:0]};
			probe_pc = lcg_next();
			start_item(ins, lcg_next(), pick(3));
			release_fetch(1'b0);
			complete_exec(8 + pick(24), 1'b1, probe, probe_pc);
			take_queued(probe, probe_pc);
		end
		test_end("backpressure");

		test_start();
		for (int i = 0; i < 7; i++) begin
			r = lcg_next();
			ins = {flush_ops[i], r[26:0]};
			run_item(ins, lcg_next(), 0, 1'b1, 2 + pick(4));
		end
		test_end("flush");

		// RIN and the unused gap
		test_start();
		for (int i = 23; i <= 31; i++) begin
			r = lcg_next();
			ins = {5'(i), r[26:0]};
			run_item(ins, lcg_next(), 0, 1'b0, 1);
		end
		test_end("illegal");

		// second reset with every register dirty and an item still on offer
		test_start();
		fill_regs();
		read_all_regs();
		r = lcg_next();
		ins = {OP_ADD, r[26:0]};
		start_item(ins, lcg_next(), 0);
		rst = 1'b1;
		in_req = 1'b0;
		repeat (8) step_cycle();
		rst = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		check_value("in_ack", in_ack, 1'b0);
		check_value("out_req", out_req, 1'b0);
		read_all_regs();
		test_end("reset_mid");

		total = errors + u_decode_stage.u_decode_stage_assert.fail_count;
		$display("tests %0d checks %0d errors %0d assertion failures %0d", tests, checks,
			errors, u_decode_stage.u_decode_stage_assert.fail_count);
		if (total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
